// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // Base opcodes handled by the short ALU.
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ctl_add  = 4'd0,
        ctl_sub  = 4'd1,
        ctl_sll  = 4'd2,
        ctl_slt  = 4'd3,
        ctl_sltu = 4'd4,
        ctl_xor  = 4'd5,
        ctl_srl  = 4'd6,
        ctl_sra  = 4'd7,
        ctl_or   = 4'd8,
        ctl_and  = 4'd9
    } alu_ctl_e;

    typedef enum logic [1:0] {
        imm_none = 2'b00,
        imm_i    = 2'b01,
        imm_u    = 2'b10
    } imm_src_e;

    typedef enum logic [1:0] {
        op_add_only = 2'b00,
        op_reg_reg  = 2'b10,
        op_reg_imm  = 2'b11
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_view_t;

    typedef struct packed {
        logic [19:0]           imm_hi;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_view_t;

    // One instruction word, seen as R-type fields or as a U-type immediate.
    typedef union packed {
        r_view_t r_view;
        u_view_t u_view;
    } instr_u;

endpackage

`default_nettype wire

// File: source/stage_io.sv
`default_nettype none

interface control_decode_io
    import core_pkg::*;
();
    imm_src_e   imm_src;
    alu_op_e    alu_op;
    logic [2:0] funct3;
    logic       op_5_xor_6;
    logic       alu_src;
    logic       reg_write;
    logic       short_alu_sel;
    logic       valid;

    modport in (
        output imm_src, alu_op, funct3, op_5_xor_6, alu_src, reg_write, short_alu_sel, valid
    );
    modport out (
        input imm_src, alu_op, funct3, op_5_xor_6, alu_src, reg_write, short_alu_sel, valid
    );
endinterface

interface data_decode_io
    import core_pkg::*;
();
    instr_u                instr;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;

    modport in (output instr, pc, rs1, rs2, rd, rd1, rd2);
    modport out (input instr, pc, rs1, rs2, rd, rd1, rd2);
endinterface

interface control_dispatch_io
    import core_pkg::*;
();
    alu_ctl_e alu_control;
    logic     alu_src;
    logic     reg_write;
    logic     short_alu_en;
    // Operand A comes from the pc (AUIPC).
    logic     pc_src;

    modport in (output alu_control, alu_src, reg_write, short_alu_en, pc_src);
    modport out (input alu_control, alu_src, reg_write, short_alu_en, pc_src);
endinterface

interface data_dispatch_io
    import core_pkg::*;
();
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;
    logic [xlen-1:0]       imm_ext;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;

    modport in (output rd1, rd2, imm_ext, pc, rs1, rs2, rd);
    modport out (input rd1, rd2, imm_ext, pc, rs1, rs2, rd);
endinterface

`default_nettype wire

// File: source/extend.sv
`default_nettype none

module extend
    import core_pkg::*;
(
    input  instr_u          instr,
    input  imm_src_e        imm_src,
    output logic [xlen-1:0] imm_ext
);

    always_comb begin
        case (imm_src)
            imm_i:   imm_ext = {{(xlen-12){instr.r_view.funct7[6]}},
                                instr.r_view.funct7, instr.r_view.rs2};
            imm_u:   imm_ext = {instr.u_view.imm_hi, 12'b0};
            // Register-register forms carry no immediate.
            default: imm_ext = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/alu_decoder.sv
`default_nettype none

module alu_decoder
    import core_pkg::*;
(
    input  alu_op_e    alu_op,
    input  logic [2:0] funct3,
    input  logic       op_5_xor_6,
    input  logic       funct7_5,
    output alu_ctl_e   alu_control
);

    always_comb begin
        case (alu_op)
            op_reg_reg, op_reg_imm: begin
                case (funct3)
                    // Only OP has a sub; op_5_xor_6 is high for OP.
                    3'b000:  alu_control = (op_5_xor_6 && funct7_5) ? ctl_sub : ctl_add;
                    3'b001:  alu_control = ctl_sll;
                    3'b010:  alu_control = ctl_slt;
                    3'b011:  alu_control = ctl_sltu;
                    3'b100:  alu_control = ctl_xor;
                    3'b101:  alu_control = funct7_5 ? ctl_sra : ctl_srl;
                    3'b110:  alu_control = ctl_or;
                    default: alu_control = ctl_and;
                endcase
            end
            default: alu_control = ctl_add;
        endcase
    end

endmodule

`default_nettype wire

// File: source/decode.sv
`default_nettype none

module decode
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [6:2]            adr,
    input  logic [xlen-1:0]       dat_w,
    output logic [xlen-1:0]       dat_r,
    output logic                  ack,
    output logic                  err,
    input  logic [xlen-1:0]       result_w,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  wb_valid,
    input  logic                  wb_we,
    control_decode_io.in          control_decode_if,
    data_decode_io.in             data_decode_if
);
    logic [xlen-1:0]       regs [2**reg_addr_w];
    logic [xlen-1:0]       pc;
    instr_u                word;
    logic                  req;
    logic                  legal;
    logic                  accept;
    imm_src_e              imm_src_n;
    alu_op_e               alu_op_n;
    logic                  alu_src_n;
    logic [reg_addr_w-1:0] rs1_n;
    logic [reg_addr_w-1:0] rs2_n;

    // Register read with write-first bypass from writeback.
    function automatic logic [xlen-1:0] rf_read(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_valid && wb_we && wb_rd == addr) begin
            return result_w;
        end
        return regs[addr];
    endfunction

    assign word = dat_w;

    // New request only; ignore the strobe still held during ack.
    assign req = cyc && stb && !ack && !err;
    assign accept = req && we && legal;

    always_comb begin
        legal = 1'b0;
        imm_src_n = imm_none;
        alu_op_n = op_add_only;
        alu_src_n = 1'b1;
        rs1_n = word.r_view.rs1;
        rs2_n = '0;
        case (word.r_view.opcode)
            opc_op: begin
                legal = word.r_view.funct7 == 7'h00 ||
                        (word.r_view.funct7 == 7'h20 &&
                         (word.r_view.funct3 == 3'b000 || word.r_view.funct3 == 3'b101));
                alu_op_n = op_reg_reg;
                alu_src_n = 1'b0;
                rs2_n = word.r_view.rs2;
            end
            opc_op_imm: begin
                if (word.r_view.funct3 == 3'b001) begin
                    legal = word.r_view.funct7 == 7'h00;
                end else if (word.r_view.funct3 == 3'b101) begin
                    legal = word.r_view.funct7 == 7'h00 || word.r_view.funct7 == 7'h20;
                end else begin
                    legal = 1'b1;
                end
                imm_src_n = imm_i;
                alu_op_n = op_reg_imm;
            end
            opc_lui, opc_auipc: begin
                legal = 1'b1;
                imm_src_n = imm_u;
                rs1_n = '0;
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_we && wb_rd != '0) begin
            regs[wb_rd] <= result_w;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
            err <= 1'b0;
            pc <= '0;
            control_decode_if.valid <= 1'b0;
        end else begin
            ack <= req && (!we || legal);
            err <= req && we && !legal;
            control_decode_if.valid <= accept;
            if (accept) begin
                pc <= pc + xlen'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !we) begin
            dat_r <= rf_read(adr);
        end
        if (accept) begin
            control_decode_if.imm_src <= imm_src_n;
            control_decode_if.alu_op <= alu_op_n;
            control_decode_if.funct3 <= word.r_view.funct3;
            control_decode_if.op_5_xor_6 <= word.r_view.opcode[5] ^ word.r_view.opcode[6];
            control_decode_if.alu_src <= alu_src_n;
            control_decode_if.reg_write <= word.u_view.rd != '0;
            control_decode_if.short_alu_sel <= legal;
            data_decode_if.instr <= word;
            data_decode_if.pc <= pc;
            data_decode_if.rs1 <= rs1_n;
            data_decode_if.rs2 <= rs2_n;
            data_decode_if.rd <= word.u_view.rd;
            data_decode_if.rd1 <= rf_read(rs1_n);
            data_decode_if.rd2 <= rf_read(rs2_n);
        end
    end

endmodule

`default_nettype wire

// File: source/dispatch.sv
`default_nettype none

module dispatch
    import core_pkg::*;
(
    control_decode_io.out   control_decode_if,
    data_decode_io.out      data_decode_if,
    control_dispatch_io.in  control_dispatch_if,
    data_dispatch_io.in     data_dispatch_if,
    input  logic [xlen-1:0] result_w,
    input  logic            forward_rd1_dp,
    input  logic            forward_rd2_dp
);

    extend u_extend (
        .instr   (data_decode_if.instr),
        .imm_src (control_decode_if.imm_src),
        .imm_ext (data_dispatch_if.imm_ext)
    );

    alu_decoder u_alu_decoder (
        .alu_op      (control_decode_if.alu_op),
        .funct3      (control_decode_if.funct3),
        .op_5_xor_6  (control_decode_if.op_5_xor_6),
        .funct7_5    (data_decode_if.instr.r_view.funct7[5]),
        .alu_control (control_dispatch_if.alu_control)
    );

    // Short ALU is the only unit.
    assign control_dispatch_if.short_alu_en =
        control_decode_if.valid && control_decode_if.short_alu_sel;
    assign control_dispatch_if.alu_src = control_decode_if.alu_src;
    assign control_dispatch_if.reg_write = control_decode_if.reg_write;
    assign control_dispatch_if.pc_src = data_decode_if.instr.r_view.opcode == opc_auipc;

    assign data_dispatch_if.rd1 = forward_rd1_dp ? result_w : data_decode_if.rd1;
    assign data_dispatch_if.rd2 = forward_rd2_dp ? result_w : data_decode_if.rd2;
    assign data_dispatch_if.pc = data_decode_if.pc;
    assign data_dispatch_if.rs1 = data_decode_if.rs1;
    assign data_dispatch_if.rs2 = data_decode_if.rs2;
    assign data_dispatch_if.rd = data_decode_if.rd;

endmodule

`default_nettype wire

// File: source/hazard.sv
`default_nettype none

module hazard
    import core_pkg::*;
(
    data_dispatch_io.out          data_dispatch_if,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  wb_valid,
    input  logic                  wb_we,
    output logic                  forward_rd1_dp,
    output logic                  forward_rd2_dp
);
    logic wb_live;

    // x0 is never forwarded.
    assign wb_live = wb_valid && wb_we && wb_rd != '0;

    assign forward_rd1_dp = wb_live && wb_rd == data_dispatch_if.rs1;
    assign forward_rd2_dp = wb_live && wb_rd == data_dispatch_if.rs2;

endmodule

`default_nettype wire

// File: source/execute.sv
`default_nettype none

module execute
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    control_dispatch_io.out       control_dispatch_if,
    data_dispatch_io.out          data_dispatch_if,
    output logic [xlen-1:0]       result_w,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic                  wb_valid,
    output logic                  wb_we,
    output logic                  retire_valid,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_pc
);
    logic                  ex_valid;
    logic                  ex_we;
    logic                  ex_alu_src;
    logic                  ex_pc_src;
    alu_ctl_e              ex_ctl;
    logic [xlen-1:0]       ex_rd1;
    logic [xlen-1:0]       ex_rd2;
    logic [xlen-1:0]       ex_imm;
    logic [xlen-1:0]       ex_pc;
    logic [reg_addr_w-1:0] ex_rd;
    logic [xlen-1:0]       src_a;
    logic [xlen-1:0]       src_b;
    logic [xlen-1:0]       alu_y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_we <= 1'b0;
            wb_valid <= 1'b0;
            wb_we <= 1'b0;
        end else begin
            ex_valid <= control_dispatch_if.short_alu_en;
            ex_we <= control_dispatch_if.short_alu_en && control_dispatch_if.reg_write;
            wb_valid <= ex_valid;
            wb_we <= ex_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_src <= control_dispatch_if.alu_src;
        ex_pc_src <= control_dispatch_if.pc_src;
        ex_ctl <= control_dispatch_if.alu_control;
        ex_rd1 <= data_dispatch_if.rd1;
        ex_rd2 <= data_dispatch_if.rd2;
        ex_imm <= data_dispatch_if.imm_ext;
        ex_pc <= data_dispatch_if.pc;
        ex_rd <= data_dispatch_if.rd;
        result_w <= alu_y;
        wb_rd <= ex_rd;
        retire_pc <= ex_pc;
    end

    assign src_a = ex_pc_src ? ex_pc : ex_rd1;
    assign src_b = ex_alu_src ? ex_imm : ex_rd2;

    always_comb begin
        case (ex_ctl)
            ctl_add:  alu_y = src_a + src_b;
            ctl_sub:  alu_y = src_a - src_b;
            ctl_sll:  alu_y = src_a << src_b[4:0];
            ctl_slt:  alu_y = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ctl_sltu: alu_y = {{(xlen-1){1'b0}}, src_a < src_b};
            ctl_xor:  alu_y = src_a ^ src_b;
            ctl_srl:  alu_y = src_a >> src_b[4:0];
            ctl_sra:  alu_y = $unsigned($signed(src_a) >>> src_b[4:0]);
            ctl_or:   alu_y = src_a | src_b;
            ctl_and:  alu_y = src_a & src_b;
            default:  alu_y = '0;
        endcase
    end

    assign retire_valid = wb_valid;
    assign retire_rd = wb_rd;

endmodule

`default_nettype wire

// File: source/issue_top.sv
`default_nettype none

module issue_top
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [6:2]            adr,
    input  logic [xlen-1:0]       dat_w,
    output logic [xlen-1:0]       dat_r,
    output logic                  ack,
    output logic                  err,
    output logic                  retire_valid,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_result,
    output logic [xlen-1:0]       retire_pc
);
    logic [xlen-1:0]       result_w;
    logic [reg_addr_w-1:0] wb_rd;
    logic                  wb_valid;
    logic                  wb_we;
    logic                  forward_rd1_dp;
    logic                  forward_rd2_dp;

    control_decode_io   control_decode_if ();
    data_decode_io      data_decode_if ();
    control_dispatch_io control_dispatch_if ();
    data_dispatch_io    data_dispatch_if ();

    decode u_decode (
        .clk               (clk),
        .rst_n             (rst_n),
        .cyc               (cyc),
        .stb               (stb),
        .we                (we),
        .adr               (adr),
        .dat_w             (dat_w),
        .dat_r             (dat_r),
        .ack               (ack),
        .err               (err),
        .result_w          (result_w),
        .wb_rd             (wb_rd),
        .wb_valid          (wb_valid),
        .wb_we             (wb_we),
        .control_decode_if (control_decode_if),
        .data_decode_if    (data_decode_if)
    );

    dispatch u_dispatch (
        .control_decode_if   (control_decode_if),
        .data_decode_if      (data_decode_if),
        .control_dispatch_if (control_dispatch_if),
        .data_dispatch_if    (data_dispatch_if),
        .result_w            (result_w),
        .forward_rd1_dp      (forward_rd1_dp),
        .forward_rd2_dp      (forward_rd2_dp)
    );

    hazard u_hazard (
        .data_dispatch_if (data_dispatch_if),
        .wb_rd            (wb_rd),
        .wb_valid         (wb_valid),
        .wb_we            (wb_we),
        .forward_rd1_dp   (forward_rd1_dp),
        .forward_rd2_dp   (forward_rd2_dp)
    );

    execute u_execute (
        .clk                 (clk),
        .rst_n               (rst_n),
        .control_dispatch_if (control_dispatch_if),
        .data_dispatch_if    (data_dispatch_if),
        .result_w            (result_w),
        .wb_rd               (wb_rd),
        .wb_valid            (wb_valid),
        .wb_we               (wb_we),
        .retire_valid        (retire_valid),
        .retire_rd           (retire_rd),
        .retire_pc           (retire_pc)
    );

    assign retire_result = result_w;

endmodule

`default_nettype wire

// File: verification/issue_checker.sv
`default_nettype none

module issue_checker (
    input logic clk,
    input logic rst_n,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic ack,
    input logic err,
    input logic retire_valid
);
    logic new_req;
    logic req_we;
    int   fail_count = 0;

    assign new_req = cyc && stb && !ack && !err;

    // Direction of the request being answered.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_we <= 1'b0;
        end else if (new_req) begin
            req_we <= we;
        end
    end

    answer_next_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) new_req |=> (ack || err)
    ) else begin
        fail_count++;
        $error("request was not answered in the following cycle");
    end

    ack_err_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(ack && err)
    ) else begin
        fail_count++;
        $error("ack and err are high together");
    end

    // Retire follows a write ack by exactly two cycles.
    retire_after_ack: assert property (
        @(posedge clk) disable iff (!rst_n) retire_valid == $past(ack && req_we, 2)
    ) else begin
        fail_count++;
        $error("retire_valid does not follow a write ack by two cycles");
    end

endmodule

bind issue_top issue_checker u_issue_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .ack          (ack),
    .err          (err),
    .retire_valid (retire_valid)
);

`default_nettype wire

// File: verification/issue_tb.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end
endmodule

module issue_tb;
    localparam int n_requests = 114;
    localparam int cycle_limit = 20 * n_requests + 100;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] result;
        logic [31:0] pc;
    } retire_t;

    logic        clk;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [6:2]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic        err;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_result;
    logic [31:0] retire_pc;

    logic [31:0] regs_m [32];
    logic [31:0] pc_m;
    retire_t     expect_q [$];
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    issue_top u_issue_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .dat_w         (dat_w),
        .dat_r         (dat_r),
        .ack           (ack),
        .err           (err),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_result (retire_result),
        .retire_pc     (retire_pc)
    );

    function automatic logic legal_word(input logic [31:0] w);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        case (w[6:0])
            7'b0110011: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            7'b0010011: return f3 == 3'd1 ? f7 == 7'h00 :
                               f3 == 3'd5 ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            7'b0110111, 7'b0010111: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // RV32I result of one instruction against the model state.
    function automatic logic [31:0] model_result(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a = regs_m[w[19:15]];
        b = (w[6:0] == 7'b0110011) ? regs_m[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh = b[4:0];
        if (w[6:0] == 7'b0110111) begin
            return {w[31:12], 12'b0};
        end
        if (w[6:0] == 7'b0010111) begin
            return pc_m + {w[31:12], 12'b0};
        end
        case (w[14:12])
            3'd0: return (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] random_alu_word(input logic [4:0] rs1,
                                                    input logic [4:0] rs2,
                                                    input logic [4:0] rd);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3 = 3'($urandom);
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        if ($urandom_range(0, 1) == 1) begin
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end
        imm = 12'($urandom);
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm[11:5] = (f3 == 3'd5) ? f7 : 7'h00;
        end
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One-cycle strobe, so the next request may start two cycles later.
    task automatic bus_cycle(input logic write, input logic [4:0] addr, input logic [31:0] wdata,
                             output logic got_ack, output logic got_err,
                             output logic [31:0] rdata);
        int wait_cycles;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= write;
        adr <= addr;
        dat_w <= wdata;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        wait_cycles = 0;
        @(negedge clk);
        while (!ack && !err && wait_cycles < 4) begin
            wait_cycles++;
            @(negedge clk);
        end
        got_ack = ack;
        got_err = err;
        rdata = dat_r;
    endtask

    task automatic issue(input logic [31:0] w);
        logic        got_ack;
        logic        got_err;
        logic [31:0] rdata;
        retire_t     item;
        bus_cycle(1'b1, 5'd0, w, got_ack, got_err, rdata);
        checks++;
        if (legal_word(w)) begin
            assert (got_ack && !got_err) else begin
                errors++;
                $display("Write of legal word %h was not acknowledged", w);
            end
            item.rd = w[11:7];
            item.result = model_result(w);
            item.pc = pc_m;
            expect_q.push_back(item);
            if (w[11:7] != 5'd0) begin
                regs_m[w[11:7]] = item.result;
            end
            pc_m = pc_m + 32'd4;
        end else begin
            assert (got_err && !got_ack) else begin
                errors++;
                $display("Write of unsupported word %h was not rejected with err", w);
            end
        end
    endtask

    task automatic bus_read(input logic [4:0] idx, output logic [31:0] data);
        logic got_ack;
        logic got_err;
        bus_cycle(1'b0, idx, 32'h0, got_ack, got_err, data);
        checks++;
        assert (got_ack && !got_err) else begin
            errors++;
            $display("Read of x%0d was not acknowledged", idx);
        end
    endtask

    task automatic drain();
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic report(input string name, input int errors_before);
        $display("Test %s finished with %0d errors", name, errors - errors_before);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= cycle_limit);
        $display("Timeout after %0d cycles, the run did not finish", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    always @(negedge clk) begin
        retire_t item;
        if (rst_n && retire_valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("Retire seen with no instruction outstanding");
            end else begin
                item = expect_q.pop_front();
                check_value("retire_rd", 32'(item.rd), 32'(retire_rd));
                check_value("retire_result", item.result, retire_result);
                check_value("retire_pc", item.pc, retire_pc);
            end
        end
    end

    initial begin
        int          mark;
        int          fails;
        logic [31:0] w;
        logic [31:0] data;
        logic [4:0]  prev_rd;
        logic [4:0]  rd;
        void'($urandom(64596));
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        adr <= '0;
        dat_w <= '0;
        pc_m = '0;
        for (int i = 0; i < 32; i++) begin
            regs_m[5'(i)] = '0;
        end
        wait (rst_n === 1'b1);

        mark = errors;
        for (int i = 0; i < 40; i++) begin
            issue(random_alu_word(5'($urandom), 5'($urandom), 5'($urandom)));
        end
        drain();
        report("alu_random", mark);

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            w = {20'($urandom), 5'($urandom_range(1, 31)),
                 (i % 2 == 0) ? 7'b0110111 : 7'b0010111};
            issue(w);
        end
        drain();
        report("lui_auipc", mark);

        // Chain 1 leaves one idle cycle so reads meet the register-file write.
        mark = errors;
        for (int c = 0; c < 3; c++) begin
            prev_rd = 5'($urandom_range(1, 31));
            for (int i = 0; i < 8; i++) begin
                rd = 5'($urandom_range(1, 31));
                if (c == 1) begin
                    @(posedge clk);
                end
                issue(random_alu_word(prev_rd, (c == 2) ? prev_rd : 5'($urandom), rd));
                prev_rd = rd;
            end
        end
        drain();
        report("dependence_chains", mark);

        mark = errors;
        issue({12'($urandom), 5'd0, 3'd0, 5'd0, 7'b0010011});
        issue({20'($urandom), 5'd0, 7'b0110111});
        issue({7'h00, 5'd0, 5'd0, 3'd0, 5'd7, 7'b0110011});
        issue({12'h005, 5'd0, 3'd6, 5'd8, 7'b0010011});
        drain();
        bus_read(5'd0, data);
        check_value("dat_r x0", 32'h0, data);
        report("register_zero", mark);

        mark = errors;
        issue({7'h00, 5'($urandom), 5'($urandom), 3'd2, 5'($urandom), 7'b0100011});
        issue({7'h00, 5'($urandom), 5'($urandom), 3'd0, 5'($urandom), 7'b1100011});
        issue({12'($urandom), 5'($urandom), 3'd2, 5'($urandom), 7'b0000011});
        issue({7'h01, 5'($urandom), 5'($urandom), 3'd0, 5'($urandom), 7'b0110011});
        issue({12'h7ff, 5'd0, 3'd0, 5'd9, 7'b0010011});
        drain();
        report("illegal_opcodes", mark);

        mark = errors;
        for (int i = 0; i < 32; i++) begin
            bus_read(5'(i), data);
            check_value($sformatf("dat_r x%0d", i), regs_m[5'(i)], data);
        end
        report("readback", mark);

        fails = u_issue_top.u_issue_checker.fail_count;
        $display("Summary: 6 tests, %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
source/core_pkg.sv
source/stage_io.sv
source/extend.sv
source/alu_decoder.sv
source/decode.sv
source/dispatch.sv
source/hazard.sv
source/execute.sv
source/issue_top.sv
verification/issue_checker.sv
verification/issue_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module issue_tb -f list.f -o issue_sim &&
out=$(./obj_dir/issue_sim +verilator+error+limit+1000) ;
echo "$out" ;
echo "$out" | grep -qx "Done: no errors" || exit 1
